// File: verilog/lc4_pkg.sv
package lc4_pkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_idx_t;

    // one-hot condition code, n in the msb, p in the lsb
    typedef logic [2:0]  nzp_t;

    // writeback trace stall codes, code 1 is not produced by a single pipe
    typedef enum logic [1:0] {
        STALL_NONE     = 2'd0,
        STALL_FLUSH    = 2'd2,
        STALL_LOAD_USE = 2'd3
    } stall_t;

    // opcodes in insn[15:12]
    localparam logic [3:0] OP_BR    = 4'b0000;
    localparam logic [3:0] OP_ARITH = 4'b0001;
    localparam logic [3:0] OP_LOGIC = 4'b0101;
    localparam logic [3:0] OP_LDR   = 4'b0110;
    localparam logic [3:0] OP_STR   = 4'b0111;
    localparam logic [3:0] OP_CONST = 4'b1001;

    // sub-opcodes in insn[5:3], ADDI only looks at bit 5
    localparam logic [2:0] ARITH_ADD  = 3'b000;
    localparam logic [2:0] ARITH_SUB  = 3'b010;
    localparam logic [2:0] ARITH_ADDI = 3'b1??;
    localparam logic [2:0] LOGIC_AND  = 3'b000;
    localparam logic [2:0] LOGIC_OR   = 3'b010;
    localparam logic [2:0] LOGIC_XOR  = 3'b011;

    // operand source selects in execute
    localparam logic [1:0] BYP_NONE = 2'd0;
    localparam logic [1:0] BYP_M    = 2'd1;
    localparam logic [1:0] BYP_W    = 2'd2;

    typedef struct packed {
        reg_idx_t rs_sel;
        reg_idx_t rt_sel;
        reg_idx_t rd_sel;
        logic     rs_re;
        logic     rt_re;
        logic     rf_we;
        logic     nzp_we;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        word_t    insn;
    } ctrl_t;

    // all fields zero, nothing is read or written
    localparam ctrl_t CTRL_BUBBLE = '0;

endpackage

// File: verilog/lc4_decoder.sv
`timescale 1ns/1ps

module lc4_decoder (
    input  lc4_pkg::word_t i_insn,
    output lc4_pkg::ctrl_t o_ctrl
);

    // instruction classes of the kept subset
    logic op_rr;
    logic op_addi;
    logic op_ldr;
    logic op_str;
    logic op_const;
    logic op_br;

    always_comb begin
        op_rr   = 1'b0;
        op_addi = 1'b0;
        case (i_insn[15:12])
            lc4_pkg::OP_ARITH: begin
                casez (i_insn[5:3])
                    lc4_pkg::ARITH_ADD, lc4_pkg::ARITH_SUB: op_rr = 1'b1;
                    lc4_pkg::ARITH_ADDI: op_addi = 1'b1;
                    default: ;
                endcase
            end
            lc4_pkg::OP_LOGIC: begin
                case (i_insn[5:3])
                    lc4_pkg::LOGIC_AND, lc4_pkg::LOGIC_OR, lc4_pkg::LOGIC_XOR: op_rr = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    assign op_ldr   = (i_insn[15:12] == lc4_pkg::OP_LDR);
    assign op_str   = (i_insn[15:12] == lc4_pkg::OP_STR);
    assign op_const = (i_insn[15:12] == lc4_pkg::OP_CONST);
    // a branch with nzp 000 never goes anywhere, so 0x0000 falls out as a no-op
    assign op_br    = (i_insn[15:12] == lc4_pkg::OP_BR) && (i_insn[11:9] != 3'b000);

    always_comb begin
        o_ctrl      = lc4_pkg::CTRL_BUBBLE;
        o_ctrl.insn = i_insn;
        if (op_rr || op_addi || op_ldr || op_str) begin
            o_ctrl.rs_sel = i_insn[8:6];
            o_ctrl.rs_re  = 1'b1;
        end
        if (op_rr) begin
            o_ctrl.rt_sel = i_insn[2:0];
            o_ctrl.rt_re  = 1'b1;
        end
        // store data register sits where rd would be
        if (op_str) begin
            o_ctrl.rt_sel   = i_insn[11:9];
            o_ctrl.rt_re    = 1'b1;
            o_ctrl.is_store = 1'b1;
        end
        if (op_rr || op_addi || op_ldr || op_const) begin
            o_ctrl.rd_sel = i_insn[11:9];
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
        end
        o_ctrl.is_load   = op_ldr;
        o_ctrl.is_branch = op_br;
    end

endmodule

// File: verilog/lc4_regfile.sv
`timescale 1ns/1ps

module lc4_regfile (
    input  logic              gwe,
    input  logic              i_rst_n,
    input  lc4_pkg::reg_idx_t i_rs_sel,
    input  lc4_pkg::reg_idx_t i_rt_sel,
    input  lc4_pkg::reg_idx_t i_rd_sel,
    input  logic              i_we,
    input  lc4_pkg::word_t    i_wdata,
    output lc4_pkg::word_t    o_rs_data,
    output lc4_pkg::word_t    o_rt_data
);

    lc4_pkg::word_t regs_q [8];

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs_q[i] <= '0;
            end
        end else if (i_we) begin
            regs_q[i_rd_sel] <= i_wdata;
        end
    end

    // writeback value is visible to decode in the same cycle
    assign o_rs_data = (i_we && i_rd_sel == i_rs_sel) ? i_wdata : regs_q[i_rs_sel];
    assign o_rt_data = (i_we && i_rd_sel == i_rt_sel) ? i_wdata : regs_q[i_rt_sel];

endmodule

// File: verilog/lc4_alu.sv
`timescale 1ns/1ps

module lc4_alu (
    input  lc4_pkg::word_t i_insn,
    input  lc4_pkg::word_t i_pc,
    input  lc4_pkg::word_t i_rs,
    input  lc4_pkg::word_t i_rt,
    output lc4_pkg::word_t o_result
);

    lc4_pkg::word_t imm5;
    lc4_pkg::word_t imm6;
    lc4_pkg::word_t imm9;

    assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
    assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
    assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

    always_comb begin
        o_result = '0;
        case (i_insn[15:12])
            // branch target, used by fetch only when taken
            lc4_pkg::OP_BR: o_result = i_pc + 16'd1 + imm9;
            lc4_pkg::OP_ARITH: begin
                casez (i_insn[5:3])
                    lc4_pkg::ARITH_ADD:  o_result = i_rs + i_rt;
                    lc4_pkg::ARITH_SUB:  o_result = i_rs - i_rt;
                    lc4_pkg::ARITH_ADDI: o_result = i_rs + imm5;
                    default: ;
                endcase
            end
            lc4_pkg::OP_LOGIC: begin
                case (i_insn[5:3])
                    lc4_pkg::LOGIC_AND: o_result = i_rs & i_rt;
                    lc4_pkg::LOGIC_OR:  o_result = i_rs | i_rt;
                    lc4_pkg::LOGIC_XOR: o_result = i_rs ^ i_rt;
                    default: ;
                endcase
            end
            // effective address for both memory ops
            lc4_pkg::OP_LDR, lc4_pkg::OP_STR: o_result = i_rs + imm6;
            lc4_pkg::OP_CONST: o_result = imm9;
            default: ;
        endcase
    end

endmodule

// File: verilog/lc4_branch_unit.sv
`timescale 1ns/1ps

module lc4_branch_unit (
    input  logic           gwe,
    input  logic           i_rst_n,
    input  lc4_pkg::ctrl_t i_x_ctrl,
    input  lc4_pkg::word_t i_x_result,
    input  lc4_pkg::ctrl_t i_m_ctrl,
    input  lc4_pkg::word_t i_m_load_data,
    output logic           o_taken
);

    lc4_pkg::nzp_t nzp_q;

    function automatic lc4_pkg::nzp_t nzp_of(input lc4_pkg::word_t value);
        return value[15] ? 3'b100 : (value == '0) ? 3'b010 : 3'b001;
    endfunction

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            nzp_q <= '0;
        end else if (i_x_ctrl.nzp_we && !i_x_ctrl.is_load) begin
            // X is younger than M, so its result wins on the same edge
            nzp_q <= nzp_of(i_x_result);
        end else if (i_m_ctrl.is_load) begin
            // load sets the codes from memory data as it leaves M
            nzp_q <= nzp_of(i_m_load_data);
        end
    end

    assign o_taken = i_x_ctrl.is_branch && ((i_x_ctrl.insn[11:9] & nzp_q) != 3'b000);

endmodule

// File: verilog/lc4_fetch_unit.sv
`timescale 1ns/1ps

module lc4_fetch_unit #(
    parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
    input  logic           gwe,
    input  logic           i_rst_n,
    input  logic           i_stall,
    input  logic           i_flush,
    input  lc4_pkg::word_t i_target,
    output lc4_pkg::word_t o_pc
);

    lc4_pkg::word_t pc_q;
    lc4_pkg::word_t pc_next;

    // redirect beats the load-use hold
    always_comb begin
        if (i_flush) begin
            pc_next = i_target;
        end else if (i_stall) begin
            pc_next = pc_q;
        end else begin
            pc_next = pc_q + 16'd1;
        end
    end

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign o_pc = pc_q;

endmodule

// File: verilog/lc4_hazard_ctrl.sv
`timescale 1ns/1ps

module lc4_hazard_ctrl (
    input  lc4_pkg::ctrl_t i_d_ctrl,
    input  lc4_pkg::ctrl_t i_x_ctrl,
    input  lc4_pkg::ctrl_t i_m_ctrl,
    input  lc4_pkg::ctrl_t i_w_ctrl,
    input  logic           i_taken,
    output logic           o_stall,
    output logic           o_flush,
    output logic [1:0]     o_rs_bypass,
    output logic [1:0]     o_rt_bypass,
    output logic           o_store_bypass
);

    logic d_reads_x_rd;
    logic load_use;

    // a register read in X is served by the youngest older writer
    function automatic logic [1:0] pick_src(
        input logic              re,
        input lc4_pkg::reg_idx_t sel,
        input lc4_pkg::ctrl_t    m_ctrl,
        input lc4_pkg::ctrl_t    w_ctrl
    );
        logic [1:0] src;
        src = lc4_pkg::BYP_NONE;
        if (re && w_ctrl.rf_we && w_ctrl.rd_sel == sel) begin
            src = lc4_pkg::BYP_W;
        end
        if (re && m_ctrl.rf_we && m_ctrl.rd_sel == sel) begin
            src = lc4_pkg::BYP_M;
        end
        return src;
    endfunction

    // store data can wait for the WM path, so it is left out here
    assign d_reads_x_rd =
        (i_d_ctrl.rs_re && i_d_ctrl.rs_sel == i_x_ctrl.rd_sel) ||
        (i_d_ctrl.rt_re && !i_d_ctrl.is_store && i_d_ctrl.rt_sel == i_x_ctrl.rd_sel);

    // a branch needs the NZP of the load, known only after M
    assign load_use = i_x_ctrl.is_load && (d_reads_x_rd || i_d_ctrl.is_branch);

    assign o_flush = i_taken;
    assign o_stall = load_use && !i_taken;

    assign o_rs_bypass = pick_src(i_x_ctrl.rs_re, i_x_ctrl.rs_sel, i_m_ctrl, i_w_ctrl);
    assign o_rt_bypass = pick_src(i_x_ctrl.rt_re, i_x_ctrl.rt_sel, i_m_ctrl, i_w_ctrl);

    // store right behind its data producer, typically a load
    assign o_store_bypass = i_m_ctrl.is_store && i_w_ctrl.rf_we &&
                            (i_w_ctrl.rd_sel == i_m_ctrl.rt_sel);

    a_rs_bypass_code: assert final (o_rs_bypass != 2'b11)
        else $error("rs bypass select took the unused code");
    a_rt_bypass_code: assert final (o_rt_bypass != 2'b11)
        else $error("rt bypass select took the unused code");

endmodule

// File: verilog/lc4_pipe_top.sv
`timescale 1ns/1ps

module lc4_pipe_top #(
    parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
    input  logic              gwe,
    input  logic              i_rst_n,
    input  lc4_pkg::word_t    i_insn,
    input  lc4_pkg::word_t    i_dmem_rdata,
    output lc4_pkg::word_t    o_pc,
    output lc4_pkg::word_t    o_dmem_addr,
    output logic              o_dmem_we,
    output lc4_pkg::word_t    o_dmem_wdata,
    output lc4_pkg::word_t    o_wb_pc,
    output lc4_pkg::word_t    o_wb_insn,
    output lc4_pkg::stall_t   o_wb_stall,
    output logic              o_wb_rf_we,
    output lc4_pkg::reg_idx_t o_wb_rf_sel,
    output lc4_pkg::word_t    o_wb_rf_data
);

    logic            stall;
    logic            flush;
    logic            taken;
    logic [1:0]      rs_bypass;
    logic [1:0]      rt_bypass;
    logic            store_bypass;
    lc4_pkg::ctrl_t  f_ctrl;

    // stage records
    lc4_pkg::word_t  d_pc;
    lc4_pkg::ctrl_t  d_ctrl;
    lc4_pkg::stall_t d_stall;
    lc4_pkg::word_t  x_pc;
    lc4_pkg::ctrl_t  x_ctrl;
    lc4_pkg::stall_t x_stall;
    lc4_pkg::word_t  m_pc;
    lc4_pkg::ctrl_t  m_ctrl;
    lc4_pkg::stall_t m_stall;
    lc4_pkg::word_t  w_pc;
    lc4_pkg::ctrl_t  w_ctrl;
    lc4_pkg::stall_t w_stall;

    // datapath values
    lc4_pkg::word_t  rf_rs;
    lc4_pkg::word_t  rf_rt;
    lc4_pkg::word_t  x_rs;
    lc4_pkg::word_t  x_rt;
    lc4_pkg::word_t  x_rs_val;
    lc4_pkg::word_t  x_rt_val;
    lc4_pkg::word_t  alu_result;
    lc4_pkg::word_t  m_result;
    lc4_pkg::word_t  m_rt;
    lc4_pkg::word_t  w_result;
    lc4_pkg::word_t  w_load_data;
    lc4_pkg::word_t  wb_data;

    function automatic lc4_pkg::word_t pick_operand(
        input logic [1:0]     sel,
        input lc4_pkg::word_t from_d,
        input lc4_pkg::word_t from_m,
        input lc4_pkg::word_t from_w
    );
        case (sel)
            lc4_pkg::BYP_M: return from_m;
            lc4_pkg::BYP_W: return from_w;
            default: return from_d;
        endcase
    endfunction

    lc4_fetch_unit #(.RESET_PC(RESET_PC)) i_lc4_fetch_unit (
        .gwe(gwe), .i_rst_n(i_rst_n), .i_stall(stall), .i_flush(flush),
        .i_target(alu_result), .o_pc(o_pc)
    );

    lc4_decoder i_lc4_decoder (.i_insn(i_insn), .o_ctrl(f_ctrl));

    lc4_regfile i_lc4_regfile (
        .gwe(gwe), .i_rst_n(i_rst_n),
        .i_rs_sel(d_ctrl.rs_sel), .i_rt_sel(d_ctrl.rt_sel), .i_rd_sel(w_ctrl.rd_sel),
        .i_we(w_ctrl.rf_we), .i_wdata(wb_data), .o_rs_data(rf_rs), .o_rt_data(rf_rt)
    );

    lc4_alu i_lc4_alu (
        .i_insn(x_ctrl.insn), .i_pc(x_pc), .i_rs(x_rs_val), .i_rt(x_rt_val),
        .o_result(alu_result)
    );

    lc4_branch_unit i_lc4_branch_unit (
        .gwe(gwe), .i_rst_n(i_rst_n), .i_x_ctrl(x_ctrl), .i_x_result(alu_result),
        .i_m_ctrl(m_ctrl), .i_m_load_data(i_dmem_rdata), .o_taken(taken)
    );

    lc4_hazard_ctrl i_lc4_hazard_ctrl (
        .i_d_ctrl(d_ctrl), .i_x_ctrl(x_ctrl), .i_m_ctrl(m_ctrl), .i_w_ctrl(w_ctrl),
        .i_taken(taken), .o_stall(stall), .o_flush(flush), .o_rs_bypass(rs_bypass),
        .o_rt_bypass(rt_bypass), .o_store_bypass(store_bypass)
    );

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            d_pc    <= '0;
            d_ctrl  <= lc4_pkg::CTRL_BUBBLE;
            d_stall <= lc4_pkg::STALL_FLUSH;
            x_pc    <= '0;
            x_ctrl  <= lc4_pkg::CTRL_BUBBLE;
            x_stall <= lc4_pkg::STALL_FLUSH;
            m_pc    <= '0;
            m_ctrl  <= lc4_pkg::CTRL_BUBBLE;
            m_stall <= lc4_pkg::STALL_FLUSH;
            w_pc    <= '0;
            w_ctrl  <= lc4_pkg::CTRL_BUBBLE;
            w_stall <= lc4_pkg::STALL_FLUSH;
        end else begin
            // D holds on a load-use stall, flush kills the fetched word
            if (!stall) begin
                d_pc    <= o_pc;
                d_ctrl  <= flush ? lc4_pkg::CTRL_BUBBLE : f_ctrl;
                d_stall <= flush ? lc4_pkg::STALL_FLUSH : lc4_pkg::STALL_NONE;
            end
            x_pc <= d_pc;
            if (flush) begin
                x_ctrl  <= lc4_pkg::CTRL_BUBBLE;
                x_stall <= lc4_pkg::STALL_FLUSH;
            end else if (stall) begin
                x_ctrl  <= lc4_pkg::CTRL_BUBBLE;
                x_stall <= lc4_pkg::STALL_LOAD_USE;
            end else begin
                x_ctrl  <= d_ctrl;
                x_stall <= d_stall;
            end
            m_pc    <= x_pc;
            m_ctrl  <= x_ctrl;
            m_stall <= x_stall;
            w_pc    <= m_pc;
            w_ctrl  <= m_ctrl;
            w_stall <= m_stall;
        end
    end

    always_ff @(posedge gwe) begin
        x_rs        <= rf_rs;
        x_rt        <= rf_rt;
        m_result    <= alu_result;
        m_rt        <= x_rt_val;
        w_result    <= m_result;
        w_load_data <= i_dmem_rdata;
    end

    assign x_rs_val = pick_operand(rs_bypass, x_rs, m_result, wb_data);
    assign x_rt_val = pick_operand(rt_bypass, x_rt, m_result, wb_data);
    assign wb_data  = w_ctrl.is_load ? w_load_data : w_result;

    // data memory is driven from the M stage only
    assign o_dmem_we    = m_ctrl.is_store;
    assign o_dmem_addr  = (m_ctrl.is_load || m_ctrl.is_store) ? m_result : '0;
    assign o_dmem_wdata = store_bypass ? wb_data : m_rt;

    assign o_wb_pc      = w_pc;
    assign o_wb_insn    = w_ctrl.insn;
    assign o_wb_stall   = w_stall;
    assign o_wb_rf_we   = w_ctrl.rf_we;
    assign o_wb_rf_sel  = w_ctrl.rd_sel;
    assign o_wb_rf_data = wb_data;

    a_dmem_addr_known: assert property (
        @(posedge gwe) disable iff (!i_rst_n) o_dmem_we |-> !$isunknown(o_dmem_addr)
    ) else $error("data memory write with unknown address");

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic gwe,
    output logic o_rst_n
);

    // 4 ns period
    initial begin
        gwe = 1'b0;
        forever #2 gwe = ~gwe;
    end

    // release on a falling edge, away from the capturing edge
    initial begin
        o_rst_n = 1'b0;
        repeat (4) @(posedge gwe);
        @(negedge gwe);
        o_rst_n <= 1'b1;
    end

endmodule

// File: verification/lc4_pipe_tb.sv
`timescale 1ns/1ps

module lc4_pipe_tb;

    localparam lc4_pkg::word_t RESET_PC = 16'h8200;
    localparam int MAX_CYCLES = 20000;

    typedef struct packed {
        lc4_pkg::word_t    pc;
        lc4_pkg::word_t    insn;
        logic              rf_we;
        lc4_pkg::reg_idx_t rf_sel;
        lc4_pkg::word_t    rf_data;
        logic              taken;
        logic              load_use_next;
    } retire_t;

    typedef struct packed {
        lc4_pkg::word_t addr;
        lc4_pkg::word_t data;
    } store_t;

    logic              gwe;
    logic              i_rst_n;
    lc4_pkg::word_t    i_insn;
    lc4_pkg::word_t    i_dmem_rdata;
    lc4_pkg::word_t    o_pc;
    lc4_pkg::word_t    o_dmem_addr;
    logic              o_dmem_we;
    lc4_pkg::word_t    o_dmem_wdata;
    lc4_pkg::word_t    o_wb_pc;
    lc4_pkg::word_t    o_wb_insn;
    lc4_pkg::stall_t   o_wb_stall;
    logic              o_wb_rf_we;
    lc4_pkg::reg_idx_t o_wb_rf_sel;
    lc4_pkg::word_t    o_wb_rf_data;

    lc4_pkg::word_t imem [65536];
    lc4_pkg::word_t dmem [65536];
    lc4_pkg::word_t prog [$];
    retire_t        exp_q [$];
    store_t         store_q [$];
    integer         seed;
    int             errors;
    int             pending_flush;
    logic           pending_lu;
    logic           checking;
    logic           started;
    logic           done;

    tb_clk_gen i_tb_clk_gen (.gwe(gwe), .o_rst_n(i_rst_n));

    lc4_pipe_top #(.RESET_PC(RESET_PC)) i_lc4_pipe_top (
        .gwe(gwe), .i_rst_n(i_rst_n), .i_insn(i_insn), .i_dmem_rdata(i_dmem_rdata),
        .o_pc(o_pc), .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we),
        .o_dmem_wdata(o_dmem_wdata), .o_wb_pc(o_wb_pc), .o_wb_insn(o_wb_insn),
        .o_wb_stall(o_wb_stall), .o_wb_rf_we(o_wb_rf_we), .o_wb_rf_sel(o_wb_rf_sel),
        .o_wb_rf_data(o_wb_rf_data)
    );

    function automatic int rnd(input int n);
        int v;
        v = $random(seed);
        return ((v % n) + n) % n;
    endfunction

    // initial data memory contents, every address bit matters
    function automatic lc4_pkg::word_t fill_word(input lc4_pkg::word_t a);
        return a ^ {a[7:0], a[15:8]} ^ 16'h3c5a;
    endfunction

    function automatic lc4_pkg::word_t enc_rr(input logic [3:0] op, input logic [2:0] sub,
                                              input logic [2:0] rd, input logic [2:0] rs,
                                              input logic [2:0] rt);
        return {op, rd, rs, sub, rt};
    endfunction

    function automatic lc4_pkg::word_t enc_addi(input logic [2:0] rd, input logic [2:0] rs,
                                                input logic [4:0] imm);
        return {lc4_pkg::OP_ARITH, rd, rs, 1'b1, imm};
    endfunction

    function automatic lc4_pkg::word_t enc_const(input logic [2:0] rd, input logic [8:0] imm);
        return {lc4_pkg::OP_CONST, rd, imm};
    endfunction

    function automatic lc4_pkg::word_t enc_mem(input logic [3:0] op, input logic [2:0] rd,
                                               input logic [2:0] rs, input logic [5:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic lc4_pkg::word_t enc_br(input logic [2:0] nzp, input logic [8:0] off);
        return {lc4_pkg::OP_BR, nzp, off};
    endfunction

    function automatic void build_program();
        int left;
        logic [2:0] rd;
        logic [2:0] rs;
        logic [2:0] rt;
        // dependent ALU chain for the MX and WX paths
        prog.push_back(enc_const(3'd1, 9'd5));
        prog.push_back(enc_addi(3'd2, 3'd1, 5'd3));
        prog.push_back(enc_rr(lc4_pkg::OP_ARITH, lc4_pkg::ARITH_ADD, 3'd3, 3'd2, 3'd1));
        prog.push_back(enc_rr(lc4_pkg::OP_ARITH, lc4_pkg::ARITH_SUB, 3'd4, 3'd3, 3'd2));
        prog.push_back(enc_rr(lc4_pkg::OP_LOGIC, lc4_pkg::LOGIC_AND, 3'd5, 3'd4, 3'd3));
        prog.push_back(enc_rr(lc4_pkg::OP_LOGIC, lc4_pkg::LOGIC_OR, 3'd6, 3'd5, 3'd4));
        prog.push_back(enc_rr(lc4_pkg::OP_LOGIC, lc4_pkg::LOGIC_XOR, 3'd7, 3'd6, 3'd1));
        prog.push_back(enc_const(3'd0, -9'sd100));
        // memory section with load-use and store bypass cases
        prog.push_back(enc_const(3'd1, 9'd64));
        prog.push_back(enc_rr(lc4_pkg::OP_ARITH, lc4_pkg::ARITH_ADD, 3'd2, 3'd1, 3'd1));
        prog.push_back(enc_mem(lc4_pkg::OP_STR, 3'd2, 3'd1, 6'd1));
        prog.push_back(enc_mem(lc4_pkg::OP_LDR, 3'd3, 3'd1, 6'd1));
        prog.push_back(enc_rr(lc4_pkg::OP_ARITH, lc4_pkg::ARITH_ADD, 3'd4, 3'd3, 3'd3));
        prog.push_back(enc_mem(lc4_pkg::OP_LDR, 3'd5, 3'd1, 6'd2));
        prog.push_back(enc_br(3'b111, 9'd1));
        prog.push_back(enc_addi(3'd7, 3'd7, 5'd1));
        prog.push_back(enc_mem(lc4_pkg::OP_LDR, 3'd6, 3'd1, 6'd1));
        prog.push_back(enc_mem(lc4_pkg::OP_STR, 3'd6, 3'd1, 6'd3));
        // each NZP outcome, taken and not taken
        prog.push_back(enc_const(3'd1, -9'sd3));
        prog.push_back(enc_br(3'b100, 9'd1));
        prog.push_back(enc_addi(3'd7, 3'd7, 5'd1));
        prog.push_back(enc_br(3'b011, 9'd2));
        prog.push_back(enc_const(3'd2, 9'd0));
        prog.push_back(enc_br(3'b010, 9'd1));
        prog.push_back(enc_addi(3'd7, 3'd7, 5'd2));
        prog.push_back(enc_br(3'b101, 9'd1));
        prog.push_back(enc_addi(3'd2, 3'd2, 5'd1));
        prog.push_back(enc_br(3'b001, 9'd1));
        prog.push_back(enc_addi(3'd7, 3'd7, 5'd3));
        prog.push_back(enc_br(3'b110, 9'd1));
        prog.push_back(enc_addi(3'd6, 3'd2, 5'd4));
        // random section, forward branches only
        for (int i = 0; i < 200; i++) begin
            rd = rnd(8);
            rs = rnd(8);
            rt = rnd(8);
            left = 199 - i;
            case (rnd(10))
                0: prog.push_back(enc_rr(lc4_pkg::OP_ARITH, lc4_pkg::ARITH_ADD, rd, rs, rt));
                1: prog.push_back(enc_rr(lc4_pkg::OP_ARITH, lc4_pkg::ARITH_SUB, rd, rs, rt));
                2: prog.push_back(enc_addi(rd, rs, rnd(32)));
                3: prog.push_back(enc_rr(lc4_pkg::OP_LOGIC, lc4_pkg::LOGIC_AND, rd, rs, rt));
                4: prog.push_back(enc_rr(lc4_pkg::OP_LOGIC, lc4_pkg::LOGIC_OR, rd, rs, rt));
                5: prog.push_back(enc_rr(lc4_pkg::OP_LOGIC, lc4_pkg::LOGIC_XOR, rd, rs, rt));
                6: prog.push_back(enc_const(rd, rnd(512)));
                7: prog.push_back(enc_mem(lc4_pkg::OP_LDR, rd, rs, rnd(64)));
                8: prog.push_back(enc_mem(lc4_pkg::OP_STR, rd, rs, rnd(64)));
                default: prog.push_back(enc_br(1 + rnd(7), (left > 6) ? rnd(7) : rnd(left + 1)));
            endcase
        end
    endfunction

    // ISA model, builds the expected retire list and store list
    function automatic void run_model();
        lc4_pkg::word_t regs [8];
        lc4_pkg::word_t pc;
        lc4_pkg::word_t insn;
        lc4_pkg::word_t res;
        lc4_pkg::word_t addr;
        lc4_pkg::nzp_t  nzp;
        retire_t        ent;
        retire_t        prev;
        logic           we;
        logic           reads_prev;
        logic           prev_load;
        int             steps;
        for (int r = 0; r < 8; r++) begin
            regs[r] = '0;
        end
        pc = RESET_PC;
        nzp = '0;
        prev_load = 1'b0;
        steps = 0;
        while (pc >= RESET_PC && int'(pc) < int'(RESET_PC) + prog.size() && steps < 4000) begin
            insn = imem[pc];
            ent = '0;
            ent.pc = pc;
            ent.insn = insn;
            we = 1'b0;
            res = '0;
            reads_prev = 1'b0;
            addr = regs[insn[8:6]] + {{10{insn[5]}}, insn[5:0]};
            case (insn[15:12])
                lc4_pkg::OP_ARITH, lc4_pkg::OP_LOGIC: begin
                    we = 1'b1;
                    reads_prev = (insn[8:6] == prev.rf_sel) ||
                                 (!(insn[15:12] == lc4_pkg::OP_ARITH && insn[5]) &&
                                  insn[2:0] == prev.rf_sel);
                    if (insn[15:12] == lc4_pkg::OP_ARITH && insn[5]) begin
                        res = regs[insn[8:6]] + {{11{insn[4]}}, insn[4:0]};
                    end else if (insn[15:12] == lc4_pkg::OP_ARITH) begin
                        res = insn[4] ? regs[insn[8:6]] - regs[insn[2:0]]
                                      : regs[insn[8:6]] + regs[insn[2:0]];
                    end else if (insn[5:3] == 3'b000) begin
                        res = regs[insn[8:6]] & regs[insn[2:0]];
                    end else if (insn[5:3] == 3'b010) begin
                        res = regs[insn[8:6]] | regs[insn[2:0]];
                    end else begin
                        res = regs[insn[8:6]] ^ regs[insn[2:0]];
                    end
                end
                lc4_pkg::OP_LDR: begin
                    we = 1'b1;
                    res = dmem[addr];
                    reads_prev = (insn[8:6] == prev.rf_sel);
                end
                lc4_pkg::OP_STR: begin
                    store_q.push_back({addr, regs[insn[11:9]]});
                    dmem[addr] = regs[insn[11:9]];
                    reads_prev = (insn[8:6] == prev.rf_sel);
                end
                lc4_pkg::OP_CONST: begin
                    we = 1'b1;
                    res = {{7{insn[8]}}, insn[8:0]};
                end
                default: begin
                    // a branch waits for the NZP of a load right before it
                    reads_prev = (insn[11:9] != 3'b000);
                    ent.taken = ((insn[11:9] & nzp) != 3'b000);
                end
            endcase
            if (prev_load && reads_prev) begin
                prev = exp_q.pop_back();
                prev.load_use_next = 1'b1;
                exp_q.push_back(prev);
            end
            if (we) begin
                regs[insn[11:9]] = res;
                nzp = res[15] ? 3'b100 : (res == '0) ? 3'b010 : 3'b001;
                ent.rf_we = 1'b1;
                ent.rf_sel = insn[11:9];
                ent.rf_data = res;
            end
            prev_load = (insn[15:12] == lc4_pkg::OP_LDR);
            exp_q.push_back(ent);
            prev = ent;
            pc = ent.taken ? pc + 16'd1 + {{7{insn[8]}}, insn[8:0]} : pc + 16'd1;
            steps++;
        end
    endfunction

    task automatic check_word(input string name, input lc4_pkg::word_t got,
                              input lc4_pkg::word_t exp);
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    // memory models, inputs change on the falling edge
    always @(negedge gwe) begin : drive_memory
        store_t st;
        if (i_rst_n === 1'b1 && o_dmem_we === 1'b1) begin
            if (store_q.size() == 0) begin
                errors++;
                $display("unexpected data memory write at address %h", o_dmem_addr);
            end else begin
                st = store_q.pop_front();
                check_word("o_dmem_addr", o_dmem_addr, st.addr);
                check_word("o_dmem_wdata", o_dmem_wdata, st.data);
            end
            dmem[o_dmem_addr] = o_dmem_wdata;
        end
        i_insn       <= imem[o_pc];
        i_dmem_rdata <= dmem[o_dmem_addr];
    end

    always @(negedge gwe) begin : compare_retire
        retire_t exp;
        if (checking && !done) begin
            if (pending_flush > 0) begin
                check_word("o_wb_stall", 16'(o_wb_stall), 16'(lc4_pkg::STALL_FLUSH));
                pending_flush--;
            end else if (pending_lu) begin
                check_word("o_wb_stall", 16'(o_wb_stall), 16'(lc4_pkg::STALL_LOAD_USE));
                pending_lu = 1'b0;
            end else if (o_wb_stall == lc4_pkg::STALL_NONE) begin
                exp = exp_q.pop_front();
                started = 1'b1;
                check_word("o_wb_pc", o_wb_pc, exp.pc);
                check_word("o_wb_insn", o_wb_insn, exp.insn);
                check_word("o_wb_rf_we", 16'(o_wb_rf_we), 16'(exp.rf_we));
                if (exp.rf_we) begin
                    check_word("o_wb_rf_sel", 16'(o_wb_rf_sel), 16'(exp.rf_sel));
                    check_word("o_wb_rf_data", o_wb_rf_data, exp.rf_data);
                end
                pending_flush = exp.taken ? 2 : 0;
                pending_lu = exp.load_use_next;
            end else if (started) begin
                errors++;
                $display("unexpected stall code %0d in the writeback trace", o_wb_stall);
            end
            done = (exp_q.size() == 0) && (pending_flush == 0) && !pending_lu;
        end
    end

    initial begin : run_test
        int cycles;
        seed = 32'hb505;
        errors = 0;
        pending_flush = 0;
        pending_lu = 1'b0;
        checking = 1'b0;
        started = 1'b0;
        done = 1'b0;
        i_insn = '0;
        i_dmem_rdata = '0;
        for (int a = 0; a < 65536; a++) begin
            imem[a] = '0;
            dmem[a] = fill_word(a);
        end
        build_program();
        for (int i = 0; i < prog.size(); i++) begin
            imem[RESET_PC + i] = prog[i];
        end
        run_model();
        // the model wrote its stores, start the DUT from the initial contents
        for (int a = 0; a < 65536; a++) begin
            dmem[a] = fill_word(a);
        end
        cycles = 0;
        while (i_rst_n !== 1'b1 && cycles < 100) begin
            @(negedge gwe);
            if (i_rst_n !== 1'b1) begin
                check_word("o_pc", o_pc, RESET_PC);
                check_word("o_dmem_we", 16'(o_dmem_we), 16'h0);
                check_word("o_wb_rf_we", 16'(o_wb_rf_we), 16'h0);
            end
            cycles++;
        end
        if (i_rst_n !== 1'b1) begin
            errors++;
            $display("timeout waiting for reset release");
        end
        check_word("o_dmem_we", 16'(o_dmem_we), 16'h0);
        check_word("o_wb_rf_we", 16'(o_wb_rf_we), 16'h0);
        checking = 1'b1;
        cycles = 0;
        while (!done && cycles < MAX_CYCLES) begin
            @(negedge gwe);
            cycles++;
        end
        checking = 1'b0;
        if (!done) begin
            errors++;
            $display("timeout with %0d instructions not retired", exp_q.size());
        end
        if (store_q.size() != 0) begin
            errors++;
            $display("%0d expected stores never reached data memory", store_q.size());
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: lc4_pipe.f
verilog/lc4_pkg.sv
verilog/lc4_decoder.sv
verilog/lc4_regfile.sv
verilog/lc4_alu.sv
verilog/lc4_branch_unit.sv
verilog/lc4_fetch_unit.sv
verilog/lc4_hazard_ctrl.sv
verilog/lc4_pipe_top.sv
verification/tb_clk_gen.sv
verification/lc4_pipe_tb.sv

// File: Bender.yml
package:
  name: lc4_pipe

sources:
  - verilog/lc4_pkg.sv
  - verilog/lc4_decoder.sv
  - verilog/lc4_regfile.sv
  - verilog/lc4_alu.sv
  - verilog/lc4_branch_unit.sv
  - verilog/lc4_fetch_unit.sv
  - verilog/lc4_hazard_ctrl.sv
  - verilog/lc4_pipe_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/lc4_pipe_tb.sv
